/* source/mem_ctrl_pkg.sv */
package mem_ctrl_pkg;

    localparam int ADDR_W = 32;
    localparam int XLEN   = 32;
    localparam int BYTE_W = 8;

    // access width of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        mem_size_e         size;
        logic              is_unsigned;
    } load_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   data;
        mem_size_e         size;
    } store_entry_t;

    // registered outputs toward the byte RAM
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BYTE_W-1:0] wdata;
        logic              is_write;
    } ram_bus_t;

    // kind of transfer currently owning the RAM port
    typedef enum logic [1:0] {
        xfer_idle  = 2'd0,
        xfer_fetch = 2'd1,
        xfer_load  = 2'd2,
        xfer_store = 2'd3
    } xfer_e;

    // number of byte beats for an access size
    function automatic logic [2:0] size_beats(mem_size_e size);
        case (size)
            size_byte: return 3'd1;
            size_half: return 3'd2;
            default:   return 3'd4;
        endcase
    endfunction

endpackage

/* source/beat_counter.sv */
`timescale 1ns/1ps

module beat_counter (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [2:0] total,
    output logic [2:0] beat,
    output logic       last_beat,
    output logic       busy
);

    logic       running;
    logic [2:0] total_q;

    assign last_beat = running && (beat == total_q);
    // final beat frees the counter for a back-to-back start
    assign busy      = running && (beat != total_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            beat    <= 3'd0;
        end else if (start) begin
            running <= 1'b1;
            beat    <= 3'd0;
        end else if (last_beat) begin
            running <= 1'b0;
        end else if (running) begin
            beat <= beat + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) total_q <= total;
    end

    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

endmodule

/* source/store_buffer.sv */
`timescale 1ns/1ps

module store_buffer import mem_ctrl_pkg::*; #(
    parameter int STORE_DEPTH = 8
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         push,
    input  store_entry_t push_entry,
    input  logic         pop,
    output store_entry_t head,
    output logic         empty,
    output logic         full
);

    localparam int PTR_W = (STORE_DEPTH > 1) ? $clog2(STORE_DEPTH) : 1;
    localparam int CNT_W = $clog2(STORE_DEPTH + 1);

    store_entry_t     entries [STORE_DEPTH];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;

    // wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(STORE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head  = entries[head_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(STORE_DEPTH));

    always_ff @(posedge clk) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) tail_ptr <= ptr_next(tail_ptr);
            if (pop) head_ptr <= ptr_next(head_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) entries[tail_ptr] <= push_entry;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push && full |-> pop);

endmodule

/* source/ram_port_driver.sv */
`timescale 1ns/1ps

module ram_port_driver import mem_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  xfer_e             xfer,
    input  logic [ADDR_W-1:0] xfer_addr,
    input  mem_size_e         xfer_size,
    input  logic [XLEN-1:0]   xfer_data,
    input  logic [2:0]        beat,
    input  logic              busy,
    output ram_bus_t          ram,
    output logic              rd_tag_valid,
    output logic [1:0]        rd_tag_lane
);

    logic              issue;
    logic [1:0]        lane;
    logic [ADDR_W-1:0] addr_q;
    logic [BYTE_W-1:0] wdata_q;
    logic              write_q;
    logic              tag_valid_q;
    logic [1:0]        tag_lane_q;

    // address beats only, trailing latency beats issue nothing
    assign issue = busy && (beat < size_beats(xfer_size));
    assign lane  = beat[1:0];

    assign ram = '{addr: addr_q, wdata: wdata_q, is_write: write_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            write_q      <= 1'b0;
            tag_valid_q  <= 1'b0;
            rd_tag_valid <= 1'b0;
        end else begin
            write_q      <= issue && (xfer == xfer_store);
            tag_valid_q  <= issue && (xfer != xfer_store);
            rd_tag_valid <= tag_valid_q;
        end
    end

    // address holds between transfers
    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q  <= xfer_addr + ADDR_W'(beat);
            wdata_q <= xfer_data[lane*BYTE_W +: BYTE_W];
        end
        tag_lane_q  <= lane;
        rd_tag_lane <= tag_lane_q;
    end

endmodule

/* source/read_assembler.sv */
`timescale 1ns/1ps

module read_assembler import mem_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_tag_valid,
    input  logic [1:0]        rd_tag_lane,
    input  logic [BYTE_W-1:0] ram_rdata,
    input  logic              read_done,
    input  xfer_e             xfer,
    input  mem_size_e         xfer_size,
    input  logic              load_unsigned,
    output logic              fetch_valid,
    output logic [XLEN-1:0]   fetch_inst,
    output logic              load_valid,
    output logic [XLEN-1:0]   load_value
);

    logic [XLEN-1:0] word_q;
    logic [XLEN-1:0] ext_value;
    logic            sign_bit;

    // little-endian, lane 0 is the lowest address
    always_ff @(posedge clk) begin
        if (rd_tag_valid) word_q[rd_tag_lane*BYTE_W +: BYTE_W] <= ram_rdata;
    end

    always_comb begin
        case (xfer_size)
            size_byte: begin
                sign_bit  = word_q[BYTE_W-1] & ~load_unsigned;
                ext_value = {{(XLEN-BYTE_W){sign_bit}}, word_q[BYTE_W-1:0]};
            end
            size_half: begin
                sign_bit  = word_q[2*BYTE_W-1] & ~load_unsigned;
                ext_value = {{(XLEN-2*BYTE_W){sign_bit}}, word_q[2*BYTE_W-1:0]};
            end
            default: begin
                sign_bit  = word_q[XLEN-1];
                ext_value = word_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
            load_valid  <= 1'b0;
        end else begin
            fetch_valid <= read_done && (xfer == xfer_fetch);
            load_valid  <= read_done && (xfer == xfer_load);
        end
    end

    // results hold until the next completion
    always_ff @(posedge clk) begin
        if (read_done && (xfer == xfer_fetch)) fetch_inst <= word_q;
        if (read_done && (xfer == xfer_load)) load_value <= ext_value;
    end

endmodule

/* source/mem_arbiter_fsm.sv */
`timescale 1ns/1ps

module mem_arbiter_fsm import mem_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_req,
    input  logic [ADDR_W-1:0] fetch_pc,
    input  logic              load_req,
    input  load_req_t         load_info,
    input  logic              rollback,
    input  logic              sb_empty,
    input  store_entry_t      sb_head,
    input  logic              last_beat,
    output logic              sb_pop,
    output logic              beat_start,
    output logic [2:0]        beat_total,
    output xfer_e             xfer,
    output logic [ADDR_W-1:0] xfer_addr,
    output mem_size_e         xfer_size,
    output logic [XLEN-1:0]   xfer_data,
    output logic              load_unsigned,
    output logic              read_done
);

    logic              fetch_pend;
    logic [ADDR_W-1:0] fetch_pc_q;
    logic              load_pend;
    load_req_t         load_q;
    logic              aborted;
    logic              decide;
    logic              reading;
    logic              fetch_avail;
    logic              load_avail;
    logic              store_avail;
    xfer_e             pick;

    // port is free when idle or on the final beat of a transfer
    assign decide      = (xfer == xfer_idle) || last_beat;
    assign reading     = (xfer == xfer_fetch) || (xfer == xfer_load);
    assign fetch_avail = fetch_pend && !rollback;
    assign load_avail  = load_pend && !rollback;
    assign store_avail = !sb_empty;

    always_comb begin
        pick = xfer_idle;
        if (decide) begin
            case (xfer)
                xfer_fetch: begin
                    if (store_avail) pick = xfer_store;
                    else if (load_avail) pick = xfer_load;
                    else if (fetch_avail) pick = xfer_fetch;
                end
                // a store always hands back to idle
                xfer_store: pick = xfer_idle;
                // idle and the end of a load share one order
                default: begin
                    if (store_avail) pick = xfer_store;
                    else if (fetch_avail) pick = xfer_fetch;
                    else if (load_avail) pick = xfer_load;
                end
            endcase
        end
    end

    // reads run two extra beats for the RAM and tag pipe latency
    always_comb begin
        case (pick)
            xfer_store: beat_total = size_beats(sb_head.size);
            xfer_fetch: beat_total = size_beats(size_word) + 3'd2;
            xfer_load:  beat_total = size_beats(load_q.size) + 3'd2;
            default:    beat_total = 3'd0;
        endcase
    end

    assign beat_start = (pick != xfer_idle);
    assign sb_pop     = (pick == xfer_store);
    assign read_done  = last_beat && reading && !aborted && !rollback;

    always_ff @(posedge clk) begin
        if (reset) begin
            xfer       <= xfer_idle;
            fetch_pend <= 1'b0;
            load_pend  <= 1'b0;
            aborted    <= 1'b0;
        end else begin
            if (decide) xfer <= pick;
            if (rollback) begin
                fetch_pend <= 1'b0;
                load_pend  <= 1'b0;
            end else begin
                if (fetch_req) fetch_pend <= 1'b1;
                else if (pick == xfer_fetch) fetch_pend <= 1'b0;
                if (load_req) load_pend <= 1'b1;
                else if (pick == xfer_load) load_pend <= 1'b0;
            end
            // running read keeps its beats but loses its result
            if (decide) aborted <= 1'b0;
            else if (rollback && reading) aborted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req) fetch_pc_q <= fetch_pc;
        if (load_req) load_q <= load_info;
        case (pick)
            xfer_fetch: begin
                xfer_addr <= fetch_pc_q;
                xfer_size <= size_word;
            end
            xfer_load: begin
                xfer_addr     <= load_q.addr;
                xfer_size     <= load_q.size;
                load_unsigned <= load_q.is_unsigned;
            end
            xfer_store: begin
                xfer_addr <= sb_head.addr;
                xfer_size <= sb_head.size;
                xfer_data <= sb_head.data;
            end
            default: ;
        endcase
    end

    // a final beat only comes from a transfer that owns the port
    a_beat_in_xfer: assert property (@(posedge clk) disable iff (reset)
        last_beat |-> (xfer != xfer_idle));

endmodule

/* source/mem_ctrl_top.sv */
`timescale 1ns/1ps

module mem_ctrl_top import mem_ctrl_pkg::*; #(
    parameter int STORE_DEPTH = 8
) (
    input  logic              clk,
    input  logic              reset,

    // fetcher
    input  logic              fetch_req,
    input  logic [ADDR_W-1:0] fetch_pc,
    output logic              fetch_valid,
    output logic [XLEN-1:0]   fetch_inst,

    // load unit
    input  logic              load_req,
    input  load_req_t         load_info,
    output logic              load_valid,
    output logic [XLEN-1:0]   load_value,

    // reorder buffer
    input  logic              store_push,
    input  store_entry_t      store_in,
    output logic              store_full,
    input  logic              rollback,

    // byte RAM
    output ram_bus_t          ram,
    input  logic [BYTE_W-1:0] ram_rdata
);

    store_entry_t      sb_head;
    logic              sb_empty;
    logic              sb_pop;

    logic              beat_start;
    logic [2:0]        beat_total;
    logic [2:0]        beat;
    logic              last_beat;
    logic              busy;

    xfer_e             xfer;
    logic [ADDR_W-1:0] xfer_addr;
    mem_size_e         xfer_size;
    logic [XLEN-1:0]   xfer_data;
    logic              load_unsigned;
    logic              read_done;

    logic              rd_tag_valid;
    logic [1:0]        rd_tag_lane;

    store_buffer #(
        .STORE_DEPTH (STORE_DEPTH)
    ) i_store_buffer (
        .clk        (clk),
        .reset      (reset),
        .push       (store_push),
        .push_entry (store_in),
        .pop        (sb_pop),
        .head       (sb_head),
        .empty      (sb_empty),
        .full       (store_full)
    );

    mem_arbiter_fsm i_mem_arbiter_fsm (
        .clk           (clk),
        .reset         (reset),
        .fetch_req     (fetch_req),
        .fetch_pc      (fetch_pc),
        .load_req      (load_req),
        .load_info     (load_info),
        .rollback      (rollback),
        .sb_empty      (sb_empty),
        .sb_head       (sb_head),
        .last_beat     (last_beat),
        .sb_pop        (sb_pop),
        .beat_start    (beat_start),
        .beat_total    (beat_total),
        .xfer          (xfer),
        .xfer_addr     (xfer_addr),
        .xfer_size     (xfer_size),
        .xfer_data     (xfer_data),
        .load_unsigned (load_unsigned),
        .read_done     (read_done)
    );

    beat_counter i_beat_counter (
        .clk       (clk),
        .reset     (reset),
        .start     (beat_start),
        .total     (beat_total),
        .beat      (beat),
        .last_beat (last_beat),
        .busy      (busy)
    );

    ram_port_driver i_ram_port_driver (
        .clk          (clk),
        .reset        (reset),
        .xfer         (xfer),
        .xfer_addr    (xfer_addr),
        .xfer_size    (xfer_size),
        .xfer_data    (xfer_data),
        .beat         (beat),
        .busy         (busy),
        .ram          (ram),
        .rd_tag_valid (rd_tag_valid),
        .rd_tag_lane  (rd_tag_lane)
    );

    read_assembler i_read_assembler (
        .clk           (clk),
        .reset         (reset),
        .rd_tag_valid  (rd_tag_valid),
        .rd_tag_lane   (rd_tag_lane),
        .ram_rdata     (ram_rdata),
        .read_done     (read_done),
        .xfer          (xfer),
        .xfer_size     (xfer_size),
        .load_unsigned (load_unsigned),
        .fetch_valid   (fetch_valid),
        .fetch_inst    (fetch_inst),
        .load_valid    (load_valid),
        .load_value    (load_value)
    );

endmodule

/* verification/byte_ram_model.sv */
`timescale 1ns/1ps

module byte_ram_model import mem_ctrl_pkg::*; #(
    parameter int ADDR_BITS = 12
) (
    input  logic              clk,
    input  ram_bus_t          ram,
    output logic [BYTE_W-1:0] rdata
);

    logic [BYTE_W-1:0] mem [2**ADDR_BITS];

    // upper address bits ignored, the array aliases
    always @(posedge clk) begin
        if (ram.is_write === 1'b1) begin
            mem[ram.addr[ADDR_BITS-1:0]] <= ram.wdata;
        end
        // old byte on a same-cycle write
        rdata <= mem[ram.addr[ADDR_BITS-1:0]];
    end

endmodule

/* verification/mem_ctrl_tb.sv */
`timescale 1ns/1ps

module mem_ctrl_tb import mem_ctrl_pkg::*; ();

    localparam int RAM_BYTES = 4096;
    localparam int TIMEOUT   = 200;
    localparam int QUIET     = 40;

    logic              clk;
    logic              reset;
    logic              fetch_req;
    logic [ADDR_W-1:0] fetch_pc;
    logic              fetch_valid;
    logic [XLEN-1:0]   fetch_inst;
    logic              load_req;
    load_req_t         load_info;
    logic              load_valid;
    logic [XLEN-1:0]   load_value;
    logic              store_push;
    store_entry_t      store_in;
    logic              store_full;
    logic              rollback;
    ram_bus_t          ram;
    logic [BYTE_W-1:0] ram_rdata;

    // expected RAM contents, stores applied in push order
    logic [BYTE_W-1:0] shadow [RAM_BYTES];
    integer            seed;
    int                write_beats;
    int                fetch_pulses;
    int                load_pulses;

    mem_ctrl_top #(
        .STORE_DEPTH (8)
    ) i_mem_ctrl_top (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .load_req    (load_req),
        .load_info   (load_info),
        .load_valid  (load_valid),
        .load_value  (load_value),
        .store_push  (store_push),
        .store_in    (store_in),
        .store_full  (store_full),
        .rollback    (rollback),
        .ram         (ram),
        .ram_rdata   (ram_rdata)
    );

    byte_ram_model #(
        .ADDR_BITS (12)
    ) i_byte_ram_model (
        .clk   (clk),
        .ram   (ram),
        .rdata (ram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // event counters, sampled before the edge updates the outputs
    always @(posedge clk) begin
        if (reset) begin
            write_beats  <= 0;
            fetch_pulses <= 0;
            load_pulses  <= 0;
        end else begin
            if (ram.is_write === 1'b1) write_beats <= write_beats + 1;
            if (fetch_valid === 1'b1) fetch_pulses <= fetch_pulses + 1;
            if (load_valid === 1'b1) load_pulses <= load_pulses + 1;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h",
                                $time, name, got, expected));
        end
    endtask

    // preload pattern, every address bit matters
    function automatic logic [BYTE_W-1:0] fill_byte(input int a);
        return 8'((a & 8'hff) ^ ((a >> 8) * 29) ^ 8'h5c);
    endfunction

    function automatic int byte_count(input mem_size_e size);
        case (size)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    // little-endian word starting at addr
    function automatic logic [XLEN-1:0] shadow_word(input logic [ADDR_W-1:0] addr);
        return {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
    endfunction

    function automatic logic [XLEN-1:0] extend_load(input logic [ADDR_W-1:0] addr,
                                                    input mem_size_e size,
                                                    input logic uns);
        logic [XLEN-1:0] raw;
        raw = shadow_word(addr);
        case (size)
            size_byte: return uns ? {24'h0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
            size_half: return uns ? {16'h0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
            default:   return raw;
        endcase
    endfunction

    function automatic void apply_store(input store_entry_t entry);
        int n;
        for (n = 0; n < byte_count(entry.size); n++) begin
            shadow[entry.addr + n] = entry.data[n*8 +: 8];
        end
    endfunction

    function automatic store_entry_t random_store(input logic [ADDR_W-1:0] base);
        store_entry_t entry;
        logic [31:0]  rnd;
        rnd        = $random(seed);
        entry.addr = base + rnd[7:0];
        entry.size = (rnd[9:8] == 2'd3) ? size_word : mem_size_e'(rnd[9:8]);
        entry.data = $random(seed);
        return entry;
    endfunction

    task automatic await_fetch_valid();
        int cycles;
        cycles = 0;
        while (fetch_valid !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (fetch_valid !== 1'b1) abort_run("fetch_valid never pulsed before the timeout");
    endtask

    task automatic await_load_valid();
        int cycles;
        cycles = 0;
        while (load_valid !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (load_valid !== 1'b1) abort_run("load_valid never pulsed before the timeout");
    endtask

    task automatic stall_while_full(output bit was_full);
        int cycles;
        cycles   = 0;
        was_full = 1'b0;
        while (store_full === 1'b1 && cycles < TIMEOUT) begin
            was_full = 1'b1;
            @(negedge clk);
            cycles++;
        end
        if (store_full !== 1'b0) abort_run("store_full stayed high past the timeout");
    endtask

    task automatic expect_write_beats(input int target);
        int cycles;
        cycles = 0;
        while (write_beats < target && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (write_beats != target) begin
            abort_run($sformatf("RAM saw %0d write beats, expected %0d",
                                write_beats, target));
        end
    endtask

    task automatic push_store(input store_entry_t entry);
        store_in   = entry;
        store_push = 1'b1;
        apply_store(entry);
        @(negedge clk);
        store_push = 1'b0;
    endtask

    task automatic compare_ram();
        int a;
        for (a = 0; a < RAM_BYTES; a++) begin
            check($sformatf("ram mem[%0h]", a), i_byte_ram_model.mem[a], shadow[a]);
        end
    endtask

    task automatic fetch_and_check(input logic [ADDR_W-1:0] pc);
        logic [XLEN-1:0] expected;
        expected  = shadow_word(pc);
        fetch_pc  = pc;
        fetch_req = 1'b1;
        @(negedge clk);
        fetch_req = 1'b0;
        await_fetch_valid();
        check($sformatf("fetch_inst @%0h", pc), fetch_inst, expected);
    endtask

    task automatic load_and_check(input logic [ADDR_W-1:0] addr, input mem_size_e size,
                                  input logic uns);
        logic [XLEN-1:0] expected;
        expected  = extend_load(addr, size, uns);
        load_info = '{addr: addr, size: size, is_unsigned: uns};
        load_req  = 1'b1;
        @(negedge clk);
        load_req = 1'b0;
        await_load_valid();
        check($sformatf("load_value @%0h size %0d", addr, size), load_value, expected);
    endtask

    task automatic fetch_test();
        fetch_and_check(32'h000);
        fetch_and_check(32'h004);
        fetch_and_check(32'h123);
        fetch_and_check(32'h9fd);
        fetch_and_check(32'hffc);
    endtask

    task automatic load_test();
        logic [ADDR_W-1:0] addrs [5];
        int                i;
        int                s;
        addrs = '{32'h010, 32'h081, 32'h1f7, 32'h3c2, 32'h7fd};
        for (i = 0; i < 5; i++) begin
            for (s = 0; s < 3; s++) begin
                load_and_check(addrs[i], mem_size_e'(s), 1'b0);
                load_and_check(addrs[i], mem_size_e'(s), 1'b1);
            end
        end
    endtask

    task automatic store_test();
        store_entry_t entries [8];
        int           first_beat;
        int           beats;
        int           n;
        bit           was_full;
        first_beat = write_beats;
        beats      = 0;
        for (n = 0; n < 8; n++) begin
            entries[n] = random_store(32'h400);
            stall_while_full(was_full);
            push_store(entries[n]);
            beats += byte_count(entries[n].size);
        end
        expect_write_beats(first_beat + beats);
        @(negedge clk);
        compare_ram();
        // read back after the buffer has drained
        for (n = 0; n < 8; n++) begin
            load_and_check(entries[n].addr, entries[n].size, 1'b0);
        end
    endtask

    task automatic full_flag_test();
        store_entry_t    entry;
        logic [XLEN-1:0] inst;
        int              first_beat;
        int              first_fetch;
        int              n;
        bit              was_full;
        bit              saw_full;
        inst        = shadow_word(32'h100);
        first_beat  = write_beats;
        first_fetch = fetch_pulses;
        saw_full    = 1'b0;
        fetch_pc    = 32'h100;
        fetch_req   = 1'b1;
        @(negedge clk);
        fetch_req = 1'b0;
        // word stores every cycle outrun the drain
        for (n = 0; n < 12; n++) begin
            entry.addr = 32'h600 + 4 * n;
            entry.data = $random(seed);
            entry.size = size_word;
            stall_while_full(was_full);
            saw_full |= was_full;
            push_store(entry);
        end
        check("store_full seen high", saw_full, 1);
        expect_write_beats(first_beat + 48);
        @(negedge clk);
        compare_ram();
        check("fetch_valid pulses", fetch_pulses - first_fetch, 1);
        check("fetch_inst @100", fetch_inst, inst);
    endtask

    task automatic rollback_test();
        store_entry_t entry;
        int           first_beat;
        int           first_load;
        int           i;
        first_beat = write_beats;
        first_load = load_pulses;
        entry.addr = 32'h701;
        entry.data = $random(seed);
        entry.size = size_byte;
        // waiting load dropped, rollback in the next cycle
        load_info = '{addr: 32'h200, size: size_word, is_unsigned: 1'b0};
        load_req  = 1'b1;
        push_store(entry);
        load_req = 1'b0;
        rollback = 1'b1;
        @(negedge clk);
        rollback = 1'b0;
        for (i = 0; i < QUIET; i++) @(negedge clk);
        // running load aborted
        load_info = '{addr: 32'h210, size: size_half, is_unsigned: 1'b1};
        load_req  = 1'b1;
        @(negedge clk);
        load_req = 1'b0;
        @(negedge clk);
        rollback = 1'b1;
        @(negedge clk);
        rollback = 1'b0;
        for (i = 0; i < QUIET; i++) @(negedge clk);
        check("load_valid pulses after rollback", load_pulses - first_load, 0);
        expect_write_beats(first_beat + 1);
        compare_ram();
        fetch_and_check(32'h700);
    endtask

    initial begin
        int a;
        seed       = 32'hf123;
        reset      = 1'b1;
        fetch_req  = 1'b0;
        fetch_pc   = '0;
        load_req   = 1'b0;
        load_info  = '0;
        store_push = 1'b0;
        store_in   = '0;
        rollback   = 1'b0;
        for (a = 0; a < RAM_BYTES; a++) begin
            i_byte_ram_model.mem[a] = fill_byte(a);
            shadow[a]               = fill_byte(a);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        fetch_test();
        load_test();
        store_test();
        full_flag_test();
        rollback_test();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* mem_ctrl_top.f */
source/mem_ctrl_pkg.sv
source/beat_counter.sv
source/store_buffer.sv
source/ram_port_driver.sv
source/read_assembler.sv
source/mem_arbiter_fsm.sv
source/mem_ctrl_top.sv
verification/byte_ram_model.sv
verification/mem_ctrl_tb.sv

/* Bender.yml */
package:
  name: mem_ctrl

sources:
  - source/mem_ctrl_pkg.sv
  - source/beat_counter.sv
  - source/store_buffer.sv
  - source/ram_port_driver.sv
  - source/read_assembler.sv
  - source/mem_arbiter_fsm.sv
  - source/mem_ctrl_top.sv
  - target: test
    files:
      - verification/byte_ram_model.sv
      - verification/mem_ctrl_tb.sv
